//--- sim.f
source/icache_pkg.sv
source/icache_line_if.sv
source/icache_line_ram.sv
source/icache_clear_counter.sv
source/icache_fsm.sv
source/icache_top.sv
tests/clock_gen.sv
tests/icache_checker.sv
tests/icache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the icache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f sim.f \
	--top-module icache_tb \
	-o icache_sim

out=$(./obj_dir/icache_sim)
echo "$out"

if grep -q "TEST PASSED" <<< "$out"; then
	exit 0
else
	exit 1
fi

//--- tests/icache_tb.sv
`default_nettype none
`timescale 1ns/100ps

module icache_tb import icache_pkg::*; ();

	localparam int TIMEOUT = 2000;
	localparam int RUN_LEN = 16;

	typedef enum {M_IDLE, M_ACTIVE, M_PREFETCH} model_state_t;

	logic clock;
	logic i_rst_n;
	logic [31:0] i_input_pc;
	logic i_stall;
	logic o_ready;
	logic [31:0] o_rdata;
	logic o_bus_request;
	logic i_bus_ready;
	logic [31:0] o_bus_address;
	logic [31:0] i_bus_rdata;

	int errors = 0;
	int checks = 0;
	int cyc = 0; // cycles since reset release
	bit timed_out = 0;

	// cache model
	fetch_addr_u model_tag [LINES];
	bit model_valid [LINES];

	logic [31:0] addrs [200];

	clock_gen clock_gen_i (.o_clock(clock));

	icache_top icache_top_i (
		.i_clock(clock),
		.i_rst_n(i_rst_n),
		.i_input_pc(i_input_pc),
		.i_stall(i_stall),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_bus_request(o_bus_request),
		.i_bus_ready(i_bus_ready),
		.o_bus_address(o_bus_address),
		.i_bus_rdata(i_bus_rdata)
	);

	bind icache_top icache_checker checker_i (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_input_pc(i_input_pc),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_bus_request(o_bus_request),
		.i_bus_ready(i_bus_ready),
		.o_bus_address(o_bus_address)
	);

	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return {addr[24:0], addr[31:25]} ^ 32'h5a3c_9e17;
	endfunction

	function automatic logic [31:0] rand_pc();
		return $urandom & 32'hffff_fffc;
	endfunction

	function automatic bit model_hit(input logic [31:0] pc);
		fetch_addr_u a;
		a.raw = pc;
		return model_valid[a.fields.index] && (model_tag[a.fields.index].raw == pc);
	endfunction

	task automatic record_fill(input logic [31:0] pc);
		fetch_addr_u a;
		a.raw = pc;
		if (cyc > LINES + 4) begin // fills during the sweep may be wiped
			model_valid[a.fields.index] = 1'b1;
			model_tag[a.fields.index] = a;
		end
	endtask

	task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (timed_out)
			$display("%s: aborted by timeout", name);
		else if (errors == errs_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - errs_before);
	endtask

	always @(posedge clock) begin
		if (!i_rst_n)
			cyc <= 0;
		else
			cyc <= cyc + 1;
	end

	// bus model answers after 0 to 5 cycles
	initial begin
		int wait_cycles;
		bit busy;
		logic [31:0] word;
		busy = 0;
		wait_cycles = 0;
		word = 32'd0;
		forever begin
			@(negedge clock);
			if (i_bus_ready) begin
				@(posedge clock);
				#1;
				i_bus_ready = 1'b0;
				i_bus_rdata = 32'd0;
				busy = 0;
			end
			else if (o_bus_request === 1'b1) begin
				if (!busy) begin
					busy = 1;
					wait_cycles = $urandom % 6;
				end
				if (wait_cycles == 0) begin
					word = mem_word(o_bus_address); // pc is held, address stable
					@(posedge clock);
					#1;
					i_bus_ready = 1'b1;
					i_bus_rdata = word;
				end
				else begin
					wait_cycles--;
				end
			end
		end
	end

	// one fetch from idle, then park the cache idle with a stall cycle
	task automatic fetch(input logic [31:0] pc, output int lat, output logic req,
			output logic [31:0] data);
		int n;
		bit done;
		lat = 0;
		req = 1'b0;
		data = 32'd0;
		done = 0;
		n = 0;
		@(posedge clock);
		#1;
		i_input_pc = pc;
		i_stall = 1'b0;
		while (!done && !timed_out) begin
			@(negedge clock);
			if (o_bus_request)
				req = 1'b1;
			if (o_ready) begin
				done = 1;
				data = o_rdata;
				lat = n;
			end
			else begin
				n++;
				if (n >= TIMEOUT) begin
					timed_out = 1;
					$display("timeout waiting for ready on fetch of %h", pc);
				end
			end
		end
		if (done && req)
			record_fill(pc);
		@(posedge clock);
		#1;
		i_stall = 1'b1;
	endtask

	task automatic stream(input logic [31:0] base, input bit use_stall);
		logic [31:0] pc;
		logic req;
		logic r;
		int got;
		int n;
		int first;
		int last;
		model_state_t ms;
		pc = base;
		req = 1'b0;
		got = 0;
		n = 0;
		first = 0;
		last = 0;
		ms = M_IDLE;
		@(posedge clock);
		#1;
		i_input_pc = pc;
		i_stall = use_stall ? (($urandom % 3) == 0) : 1'b0;
		while (got < RUN_LEN && !timed_out) begin
			@(negedge clock);
			r = o_ready;
			if (o_bus_request)
				req = 1'b1;
			if (ms == M_IDLE || (ms == M_PREFETCH && i_stall)) begin
				check_flag("ready while idle", o_ready, 1'b0);
				check_flag("request while idle", o_bus_request, 1'b0);
			end
			case (ms)
				M_IDLE: if (!i_stall) ms = M_ACTIVE;
				M_ACTIVE: if (r) ms = i_bus_ready ? M_IDLE : M_PREFETCH;
				default: begin
					if (i_stall)
						ms = M_IDLE;
					else if (!r)
						ms = M_ACTIVE;
				end
			endcase
			if (r) begin
				check_word("stream word", o_rdata, mem_word(pc));
				if (req)
					record_fill(pc);
				req = 1'b0;
				if (got == 0)
					first = n;
				last = n;
				got++;
				pc = pc + 32'd4;
			end
			n++;
			if (n >= TIMEOUT) begin
				timed_out = 1;
				$display("timeout waiting for streamed word %0d", got);
			end
			else if (got < RUN_LEN) begin
				@(posedge clock);
				#1;
				i_input_pc = pc;
				i_stall = use_stall ? (($urandom % 3) == 0) : 1'b0;
			end
		end
		if (!use_stall && !timed_out)
			check_word("stream span", 32'(last - first), 32'(RUN_LEN - 1));
		@(posedge clock);
		#1;
		i_stall = 1'b1;
	endtask

	initial begin
		int e;
		int lat;
		int n;
		logic req;
		logic exp_req;
		logic [31:0] data;
		logic [31:0] pc;
		logic [31:0] base;
		fetch_addr_u a;
		fetch_addr_u b;

		void'($urandom(10137));
		i_rst_n = 1'b0;
		i_input_pc = 32'd0;
		i_stall = 1'b1;
		i_bus_ready = 1'b0;
		i_bus_rdata = 32'd0;
		for (int i = 0; i < LINES; i++) begin
			model_valid[i] = 1'b0;
			model_tag[i].raw = 32'd0;
		end

		// reset held for 4 cycles
		e = errors;
		repeat (3) @(posedge clock);
		@(negedge clock);
		check_flag("ready in reset", o_ready, 1'b0);
		check_flag("request in reset", o_bus_request, 1'b0);
		@(posedge clock);
		#1;
		i_rst_n = 1'b1;
		@(negedge clock);
		check_flag("ready after reset", o_ready, 1'b0);
		check_flag("request after reset", o_bus_request, 1'b0);
		report_test("reset", e);

		// cold misses during the clear sweep
		e = errors;
		for (int i = 0; i < 20 && !timed_out; i++) begin
			pc = rand_pc();
			fetch(pc, lat, req, data);
			check_flag("cold miss request", req, 1'b1);
			check_word("cold miss word", data, mem_word(pc));
		end
		report_test("cold miss", e);

		n = 0;
		while (cyc <= LINES + 4 && !timed_out) begin
			@(negedge clock);
			n++;
			if (n >= TIMEOUT) begin
				timed_out = 1;
				$display("timeout waiting for the clear sweep to end");
			end
		end

		// hits
		e = errors;
		for (int i = 0; i < 200 && !timed_out; i++) begin
			addrs[i] = rand_pc();
			fetch(addrs[i], lat, req, data);
			check_word("fill word", data, mem_word(addrs[i]));
		end
		for (int i = 0; i < 100 && !timed_out; i++) begin
			pc = addrs[$urandom % 200];
			if (model_hit(pc)) begin
				fetch(pc, lat, req, data);
				check_word("hit latency", 32'(lat), 32'd1);
				check_flag("hit request", req, 1'b0);
			end
			else begin
				fetch(pc, lat, req, data);
			end
			check_word("refetch word", data, mem_word(pc));
		end
		report_test("hits", e);

		// streaming
		e = errors;
		base = rand_pc();
		for (int i = 0; i < RUN_LEN && !timed_out; i++) begin
			fetch(base + 32'(4 * i), lat, req, data);
			check_word("run fill word", data, mem_word(base + 32'(4 * i)));
		end
		if (!timed_out)
			stream(base, 1'b0);
		report_test("streaming", e);

		e = errors;
		for (int i = 0; i < 4 && !timed_out; i++)
			stream(base, 1'b1);
		report_test("stall", e);

		// aliasing on one index with another tag
		e = errors;
		for (int i = 0; i < 5 && !timed_out; i++) begin
			a.raw = rand_pc();
			b = a;
			b.fields.tag = a.fields.tag ^ TAG_BITS'(($urandom % 32'hf_ffff) + 1);
			fetch(a.raw, lat, req, data);
			check_word("alias first word", data, mem_word(a.raw));
			fetch(b.raw, lat, req, data);
			check_word("alias second word", data, mem_word(b.raw));
			exp_req = !model_hit(a.raw);
			fetch(a.raw, lat, req, data);
			check_flag("alias refetch request", req, exp_req);
			check_word("alias refetch word", data, mem_word(a.raw));
		end
		report_test("aliasing", e);

		$display("checks passed %0d, failed %0d", checks - errors, errors);
		if (errors == 0 && !timed_out) begin
			$display("TEST PASSED");
		end
		else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/icache_checker.sv
`default_nettype none
`timescale 1ns/100ps

module icache_checker (
	input wire i_clock,
	input wire i_rst_n,
	input wire [31:0] i_input_pc,
	input wire o_ready,
	input wire [31:0] o_rdata,
	input wire o_bus_request,
	input wire i_bus_ready,
	input wire [31:0] o_bus_address
);

	// request is a level held until the bus answers
	request_held: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(o_bus_request && !i_bus_ready) |=> o_bus_request)
		else $error("bus request dropped before ready");

	rdata_quiet: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		!o_ready |-> (o_rdata == 32'd0))
		else $error("rdata not zero without ready");

	ready_reset: assert property (@(posedge i_clock)
		!i_rst_n |=> !o_ready)
		else $error("ready high after reset");

	address_follows_pc: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_bus_address == i_input_pc)
		else $error("bus address differs from pc");

endmodule

`default_nettype wire

//--- tests/clock_gen.sv
`default_nettype none
`timescale 1ns/100ps

module clock_gen (
	output logic o_clock
);

	localparam real HALF_PERIOD = 2.0; // 4 ns period

	initial begin
		o_clock = 1'b0;
	end

	always begin
		#(HALF_PERIOD) o_clock = ~o_clock;
	end

endmodule

`default_nettype wire

//--- source/icache_top.sv
`default_nettype none
`timescale 1ns/100ps

module icache_top import icache_pkg::*; (
	input wire i_clock,
	input wire i_rst_n,

	// fetcher
	input wire [31:0] i_input_pc,
	input wire i_stall,
	output logic o_ready,
	output logic [31:0] o_rdata,

	// bus
	output logic o_bus_request,
	input wire i_bus_ready,
	output logic [31:0] o_bus_address,
	input wire [31:0] i_bus_rdata
);

	logic clear_active;
	logic [INDEX_BITS-1:0] clear_index;
	logic clear_done;

	icache_line_if line_if_i ();

	icache_clear_counter clear_counter_i (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.o_clear_active(clear_active),
		.o_clear_index(clear_index),
		.o_clear_done(clear_done)
	);

	icache_line_ram line_ram_i (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_clear_active(clear_active),
		.i_clear_index(clear_index),
		.i_clear_done(clear_done),
		.line(line_if_i.ram)
	);

	icache_fsm fsm_i (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_input_pc(i_input_pc),
		.i_stall(i_stall),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_bus_request(o_bus_request),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata),
		.line(line_if_i.fsm)
	);

	// bus always fetches the current pc
	assign o_bus_address = i_input_pc;

endmodule

`default_nettype wire

//--- source/icache_fsm.sv
`default_nettype none
`timescale 1ns/100ps

module icache_fsm import icache_pkg::*; (
	input wire i_clock,
	input wire i_rst_n,

	// fetcher side
	input wire [31:0] i_input_pc,
	input wire i_stall,
	output logic o_ready,
	output logic [31:0] o_rdata,

	// bus side
	output logic o_bus_request,
	input wire i_bus_ready,
	input wire [31:0] i_bus_rdata,

	icache_line_if.fsm line
);

	typedef enum logic [1:0] {
		IDLE,
		READ_SETUP,
		READ_PREFETCH,
		READ_BUS
	} state_t;

	state_t state;
	state_t next;

	fetch_addr_u pc;
	fetch_addr_u pc_ahead;
	logic [31:0] pc_tag;
	logic hit;
	logic run_ahead; // read the next sequential line

	function automatic logic [31:0] make_tag(input fetch_addr_u addr);
		return {addr.fields.tag, addr.fields.index, 2'b01};
	endfunction

	assign pc.raw = i_input_pc;
	assign pc_ahead.raw = i_input_pc + 32'd4;
	assign pc_tag = make_tag(pc);

	// rdata belongs to the index presented last cycle
	assign hit = (line.rdata.tag_word == pc_tag);

	assign line.index = run_ahead ? pc_ahead.fields.index : pc.fields.index;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= IDLE;
		end
		else begin
			state <= next;
		end
	end

	always_comb begin
		next = state;
		run_ahead = 1'b0;

		o_ready = 1'b0;
		o_rdata = '0;
		o_bus_request = 1'b0;

		line.write = 1'b0;
		line.wdata = '0;

		case (state)
			IDLE: begin
				// lines are not trusted until the sweep is done
				if (!i_stall) begin
					if (line.initialized) begin
						next = READ_SETUP;
					end
					else begin
						next = READ_BUS;
					end
				end
			end

			READ_SETUP: begin
				if (hit) begin
					o_ready = 1'b1;
					o_rdata = line.rdata.instr;
					run_ahead = 1'b1;
					next = READ_PREFETCH;
				end
				else begin
					o_bus_request = 1'b1; // miss
					next = READ_BUS;
				end
			end

			READ_PREFETCH: begin
				if (i_stall) begin
					next = IDLE; // read ahead is dropped
				end
				else if (hit) begin
					o_ready = 1'b1;
					o_rdata = line.rdata.instr;
					run_ahead = 1'b1;
				end
				else begin
					o_bus_request = 1'b1;
					next = READ_BUS;
				end
			end

			READ_BUS: begin
				o_bus_request = 1'b1;

				if (i_bus_ready) begin
					// word goes to the fetcher and into the line together
					o_ready = 1'b1;
					o_rdata = i_bus_rdata;
					line.write = 1'b1;
					line.wdata.instr = i_bus_rdata;
					line.wdata.tag_word = pc_tag;
					next = IDLE;
				end
			end

			default: begin
				next = IDLE;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- source/icache_clear_counter.sv
`default_nettype none
`timescale 1ns/100ps

module icache_clear_counter import icache_pkg::*; (
	input wire i_clock,
	input wire i_rst_n,

	output logic o_clear_active,
	output logic [INDEX_BITS-1:0] o_clear_index,
	output logic o_clear_done
);

	localparam logic [INDEX_BITS-1:0] LAST_INDEX = INDEX_BITS'(LINES - 1);

	logic last;

	assign last = (o_clear_index == LAST_INDEX);

	// sweeps every line once after reset, then parks
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_clear_active <= 1'b1;
			o_clear_index <= '0;
			o_clear_done <= 1'b0;
		end
		else if (o_clear_active) begin
			o_clear_index <= o_clear_index + 1'b1;

			if (last) begin
				o_clear_active <= 1'b0; // last line written at this edge
				o_clear_done <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/icache_line_ram.sv
`default_nettype none
`timescale 1ns/100ps

module icache_line_ram import icache_pkg::*; (
	input wire i_clock,
	input wire i_rst_n,

	// clear sweep
	input wire i_clear_active,
	input wire [INDEX_BITS-1:0] i_clear_index,
	input wire i_clear_done,

	icache_line_if.ram line
);

	line_word_t mem [LINES];

	logic [INDEX_BITS-1:0] wr_index;
	line_word_t wr_data;
	logic wr_en;

	// clear wins over a fill in the same cycle
	always_comb begin
		wr_en = 1'b0;
		wr_index = line.index;
		wr_data = line.wdata;

		if (i_clear_active) begin
			wr_en = 1'b1;
			wr_index = i_clear_index;
			wr_data = '0; // zero tag word means invalid
		end
		else if (line.write) begin
			wr_en = 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (wr_en) begin
			mem[wr_index] <= wr_data;
		end
	end

	// read always runs, one cycle latency
	always_ff @(posedge i_clock) begin
		line.rdata <= mem[line.index];
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			line.initialized <= 1'b0;
		end
		else begin
			line.initialized <= i_clear_done;
		end
	end

endmodule

`default_nettype wire

//--- source/icache_line_if.sv
`default_nettype none
`timescale 1ns/100ps

interface icache_line_if import icache_pkg::*; ();

	logic [INDEX_BITS-1:0] index; // read and fill address
	logic write;                  // fill strobe
	line_word_t wdata;
	line_word_t rdata;            // line at last cycle's index
	logic initialized;            // clear sweep finished

	modport fsm (
		output index,
		output write,
		output wdata,
		input rdata,
		input initialized
	);

	modport ram (
		input index,
		input write,
		input wdata,
		output rdata,
		output initialized
	);

endinterface

`default_nettype wire

//--- source/icache_pkg.sv
`default_nettype none

package icache_pkg;

	// cache geometry
	localparam int INDEX_BITS = 10;
	localparam int LINES = 1 << INDEX_BITS; // 1024 lines, one word each
	localparam int TAG_BITS = 32 - INDEX_BITS - 2;

	// fetch address split into its cache fields
	typedef struct packed {
		logic [TAG_BITS-1:0] tag;
		logic [INDEX_BITS-1:0] index;
		logic [1:0] offset; // always zero on aligned fetches
	} fetch_fields_t;

	// same 32-bit word, seen raw on the bus or split for the cache
	typedef union packed {
		logic [31:0] raw;
		fetch_fields_t fields;
	} fetch_addr_u;

	// one cache line
	// tag word is the fetch address with bit 1 clear and bit 0 as valid flag
	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] tag_word;
	} line_word_t;

endpackage

`default_nettype wire
